// File: arb_pkg.sv
package arb_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;
    typedef logic [7:0]  strb_t;
    typedef logic [3:0]  id_t;
    typedef logic [7:0]  len_t;   // Beats minus one
    typedef logic [1:0]  resp_t;

    // Fixed IDs stamped on the external request, one per requester
    localparam id_t FETCH_ID = 4'd0;
    localparam id_t MEM_ID   = 4'd1;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_EXOKAY = 2'b01;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    // Read channel owner
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_MEM
    } rd_state_t;

    // One write may be in flight
    typedef enum logic {
        WR_IDLE,
        WR_BUSY
    } wr_state_t;

endpackage

// File: read_arbiter.sv
`timescale 1ns/1ps

module read_arbiter
    import arb_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  fetch_arvalid,
    input  addr_t fetch_araddr,
    input  len_t  fetch_arlen,
    output logic  fetch_arready,
    input  logic  fetch_rready,
    output logic  fetch_rvalid,
    output data_t fetch_rdata,
    output resp_t fetch_rresp,
    output logic  fetch_rlast,

    input  logic  mem_arvalid,
    input  addr_t mem_araddr,
    input  len_t  mem_arlen,
    output logic  mem_arready,
    input  logic  mem_rready,
    output logic  mem_rvalid,
    output data_t mem_rdata,
    output resp_t mem_rresp,
    output logic  mem_rlast,

    output logic  io_arvalid,
    output addr_t io_araddr,
    output id_t   io_arid,
    output len_t  io_arlen,
    input  logic  io_arready,
    input  logic  io_rvalid,
    input  data_t io_rdata,
    input  resp_t io_rresp,
    input  logic  io_rlast,
    input  id_t   io_rid,
    output logic  io_rready
);

    rd_state_t state;
    logic      ar_fire;
    logic      last_fire;
    id_t       owner_id;

    assign ar_fire  = io_arvalid && io_arready;
    assign owner_id = (state == RD_FETCH) ? FETCH_ID : MEM_ID;

    // An error response ends the burst like any other
    assign last_fire = io_rvalid && io_rready && io_rlast && (io_rid == owner_id);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (ar_fire) begin
                        state <= fetch_arvalid ? RD_FETCH : RD_MEM;
                    end
                end
                RD_FETCH, RD_MEM: begin
                    if (last_fire) begin
                        state <= RD_IDLE;
                    end
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // Fetch has priority over memory on the address channel
    always_comb begin
        io_arvalid    = 1'b0;
        io_araddr     = mem_araddr;
        io_arid       = MEM_ID;
        io_arlen      = mem_arlen;
        fetch_arready = 1'b0;
        mem_arready   = 1'b0;
        if (state == RD_IDLE) begin
            if (fetch_arvalid) begin
                io_arvalid    = 1'b1;
                io_araddr     = fetch_araddr;
                io_arid       = FETCH_ID;
                io_arlen      = fetch_arlen;
                fetch_arready = io_arready;
            end else begin
                io_arvalid  = mem_arvalid;
                mem_arready = io_arready; // Held low whenever fetch is asking
            end
        end
    end

    // Payload goes to both ports but only the owner sees valid
    assign fetch_rdata = io_rdata;
    assign fetch_rresp = io_rresp;
    assign fetch_rlast = io_rlast;
    assign mem_rdata   = io_rdata;
    assign mem_rresp   = io_rresp;
    assign mem_rlast   = io_rlast;

    always_comb begin
        fetch_rvalid = 1'b0;
        mem_rvalid   = 1'b0;
        io_rready    = 1'b0;
        case (state)
            RD_FETCH: begin
                fetch_rvalid = io_rvalid;
                io_rready    = fetch_rready;
            end
            RD_MEM: begin
                mem_rvalid = io_rvalid;
                io_rready  = mem_rready;
            end
            default: begin
                io_rready = 1'b0;
            end
        endcase
    end

    // A granted address holds the channel until its burst has returned
    a_ar_held: assert property (@(posedge clk) disable iff (rst)
        ar_fire |=> !io_arvalid);

    // The fetch winner alone sees the returning beats
    a_fetch_owns: assert property (@(posedge clk) disable iff (rst)
        ar_fire && fetch_arvalid |=> !mem_rvalid && (fetch_rvalid == io_rvalid));

endmodule

// File: write_tracker.sv
`timescale 1ns/1ps

module write_tracker
    import arb_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  mem_awvalid,
    input  addr_t mem_awaddr,
    input  len_t  mem_awlen,
    output logic  mem_awready,
    input  logic  mem_wvalid,
    input  data_t mem_wdata,
    input  strb_t mem_wstrb,
    input  logic  mem_wlast,
    output logic  mem_wready,
    input  logic  mem_bready,
    output logic  mem_bvalid,
    output resp_t mem_bresp,

    output logic  io_awvalid,
    output addr_t io_awaddr,
    output id_t   io_awid,
    output len_t  io_awlen,
    input  logic  io_awready,
    output logic  io_wvalid,
    output data_t io_wdata,
    output strb_t io_wstrb,
    output logic  io_wlast,
    input  logic  io_wready,
    input  logic  io_bvalid,
    input  resp_t io_bresp,
    input  id_t   io_bid,
    output logic  io_bready
);

    wr_state_t state;
    logic      idle;
    logic      busy;
    logic      aw_fire;
    logic      b_fire;

    assign idle = (state == WR_IDLE);
    assign busy = (state == WR_BUSY);

    assign aw_fire = io_awvalid && io_awready;
    assign b_fire  = io_bvalid && io_bready && (io_bid == MEM_ID);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: if (aw_fire) state <= WR_BUSY;
                WR_BUSY: if (b_fire) state <= WR_IDLE; // Error responses also close it
                default: state <= WR_IDLE;
            endcase
        end
    end

    // Address channel is open only while nothing is in flight
    assign io_awvalid  = idle && mem_awvalid;
    assign mem_awready = idle && io_awready;
    assign io_awaddr   = mem_awaddr;
    assign io_awlen    = mem_awlen;
    assign io_awid     = MEM_ID;

    assign io_wvalid  = busy && mem_wvalid;
    assign mem_wready = busy && io_wready;
    assign io_wdata   = mem_wdata;
    assign io_wstrb   = mem_wstrb;
    assign io_wlast   = mem_wlast;

    assign mem_bvalid = busy && io_bvalid;
    assign io_bready  = busy && mem_bready;
    assign mem_bresp  = io_bresp;

    // Only one write may be in flight
    a_one_write: assert property (@(posedge clk) disable iff (rst)
        aw_fire |=> !mem_awready && !io_awvalid);

endmodule

// File: bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter
    import arb_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    // Instruction fetch read port
    input  logic  fetch_arvalid,
    input  addr_t fetch_araddr,
    input  len_t  fetch_arlen,
    output logic  fetch_arready,
    input  logic  fetch_rready,
    output logic  fetch_rvalid,
    output data_t fetch_rdata,
    output resp_t fetch_rresp,
    output logic  fetch_rlast,

    // Data memory port, reads and writes
    input  logic  mem_arvalid,
    input  addr_t mem_araddr,
    input  len_t  mem_arlen,
    output logic  mem_arready,
    input  logic  mem_rready,
    output logic  mem_rvalid,
    output data_t mem_rdata,
    output resp_t mem_rresp,
    output logic  mem_rlast,
    input  logic  mem_awvalid,
    input  addr_t mem_awaddr,
    input  len_t  mem_awlen,
    output logic  mem_awready,
    input  logic  mem_wvalid,
    input  data_t mem_wdata,
    input  strb_t mem_wstrb,
    input  logic  mem_wlast,
    output logic  mem_wready,
    input  logic  mem_bready,
    output logic  mem_bvalid,
    output resp_t mem_bresp,

    // External AXI side
    output logic  io_arvalid,
    output addr_t io_araddr,
    output id_t   io_arid,
    output len_t  io_arlen,
    input  logic  io_arready,
    input  logic  io_rvalid,
    input  data_t io_rdata,
    input  resp_t io_rresp,
    input  logic  io_rlast,
    input  id_t   io_rid,
    output logic  io_rready,
    output logic  io_awvalid,
    output addr_t io_awaddr,
    output id_t   io_awid,
    output len_t  io_awlen,
    input  logic  io_awready,
    output logic  io_wvalid,
    output data_t io_wdata,
    output strb_t io_wstrb,
    output logic  io_wlast,
    input  logic  io_wready,
    input  logic  io_bvalid,
    input  resp_t io_bresp,
    input  id_t   io_bid,
    output logic  io_bready
);

    // Port names match one to one, so the wildcard hookup is exact
    read_arbiter u_read (
        .*
    );

    write_tracker u_write (
        .*
    );

endmodule

// File: tb_monitor.sv
`timescale 1ns/1ps

module tb_monitor
    import arb_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         start,
    input  logic         done,
    input  logic [127:0] test_name,
    input  logic         test_fetch,
    input  logic         test_mem,
    input  logic         test_write,
    input  addr_t        test_addr,
    input  addr_t        test_mem_addr,
    input  len_t         test_len,
    input  resp_t        test_resp,
    input  logic         fetch_arvalid, fetch_arready, fetch_rvalid, fetch_rready, fetch_rlast,
    input  logic         mem_arready, mem_rvalid, mem_rready, mem_rlast, mem_awready,
    input  logic         mem_wlast, mem_wready, mem_bvalid, mem_bready,
    input  logic         io_arvalid, io_arready, io_rready, io_awvalid, io_awready,
    input  logic         io_wvalid, io_wready, io_wlast, io_bready,
    input  addr_t        io_araddr, io_awaddr,
    input  id_t          io_arid, io_awid,
    input  len_t         io_arlen, io_awlen,
    input  data_t        fetch_rdata, mem_rdata, mem_wdata, io_wdata,
    input  strb_t        mem_wstrb, io_wstrb,
    input  resp_t        fetch_rresp, mem_rresp, mem_bresp,
    output int           tests_done,
    output int           errors
);

    int    ar_count;
    int    fetch_done;
    int    mem_done;
    int    aw_count;
    int    w_count;
    int    b_count;
    int    test_errors;
    int    beat;
    logic  rd_busy;
    logic  rd_fetch;
    logic  wr_busy;
    addr_t rd_base;
    logic  r_fire;
    data_t r_data;
    resp_t r_resp;
    logic  r_last;

    // Read beats are followed on whichever port owns the current burst
    assign r_fire = rd_fetch ? (fetch_rvalid && fetch_rready) : (mem_rvalid && mem_rready);
    assign r_data = rd_fetch ? fetch_rdata : mem_rdata;
    assign r_resp = rd_fetch ? fetch_rresp : mem_rresp;
    assign r_last = rd_fetch ? fetch_rlast : mem_rlast;

    task automatic compare(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %0s: %0s expected %h actual %h",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic complain(input string what);
        $display("ERROR in %0s: %0s", test_name, what);
        test_errors++;
    endtask

    initial begin
        tests_done = 0;
        errors     = 0;
        rd_busy    = 1'b0;
        rd_fetch   = 1'b0;
        wr_busy    = 1'b0;
    end

    always @(posedge clk) begin
        if (start) begin
            ar_count    = 0;
            fetch_done  = 0;
            mem_done    = 0;
            aw_count    = 0;
            w_count     = 0;
            b_count     = 0;
            test_errors = 0;
            rd_busy     = 1'b0;
            wr_busy     = 1'b0;
        end else if (!rst) begin
            if (mem_arready && fetch_arvalid) complain("mem_arready is high while fetch asks");
            if (io_arvalid && rd_busy) begin
                complain("io_arvalid is high while a read is outstanding");
            end
            if (fetch_rvalid && !(rd_busy && rd_fetch)) begin
                complain("fetch_rvalid without a fetch read");
            end
            if (mem_rvalid && !(rd_busy && !rd_fetch)) begin
                complain("mem_rvalid without a memory read");
            end
            if (mem_awready && wr_busy) begin
                complain("mem_awready is high while a write is in flight");
            end
            // The owner's back-pressure reaches the external bus unchanged
            if (rd_busy) begin
                compare("io_rready", rd_fetch ? fetch_rready : mem_rready, io_rready);
            end
            if (wr_busy) begin
                compare("mem_wready", io_wready, mem_wready);
                compare("io_bready", mem_bready, io_bready);
            end
            if (rd_busy && r_fire) begin
                // Beat data is the beat address plus the beat index
                compare("rdata", {32'd0, rd_base + 32'(beat * 8)} + 64'(beat), r_data);
                compare("rresp", test_resp, r_resp);
                compare("rlast", beat == test_len, r_last);
                if (beat == test_len) begin
                    rd_busy = 1'b0;
                    if (rd_fetch) fetch_done++;
                    else mem_done++;
                end
                beat++;
            end
            if (io_arvalid && io_arready) begin
                rd_fetch = test_fetch && ar_count == 0; // Fetch must win the first grant
                rd_base  = rd_fetch ? test_addr : test_mem_addr;
                compare("io_arid", rd_fetch ? FETCH_ID : MEM_ID, io_arid);
                compare("io_araddr", rd_base, io_araddr);
                compare("io_arlen", test_len, io_arlen);
                compare("fetch_arready", rd_fetch, fetch_arready);
                compare("mem_arready", !rd_fetch, mem_arready);
                rd_busy = 1'b1;
                beat    = 0;
                ar_count++;
            end
            if (io_awvalid && io_awready) begin
                compare("io_awaddr", test_addr, io_awaddr);
                compare("io_awid", MEM_ID, io_awid);
                compare("io_awlen", test_len, io_awlen);
                wr_busy = 1'b1;
                aw_count++;
            end
            if (io_wvalid && io_wready) begin
                compare("io_wdata", mem_wdata, io_wdata);
                compare("io_wstrb", mem_wstrb, io_wstrb);
                compare("io_wlast", mem_wlast, io_wlast);
                w_count++;
            end
            if (mem_bvalid && mem_bready) begin
                compare("mem_bresp", test_resp, mem_bresp);
                wr_busy = 1'b0;
                b_count++;
            end
            if (done) begin
                compare("fetch bursts", test_fetch, fetch_done);
                compare("memory bursts", test_mem, mem_done);
                compare("write addresses", test_write, aw_count);
                compare("write responses", test_write, b_count);
                if (test_write) compare("write beats", test_len + 1, w_count);
                if (test_errors == 0) $display("PASS  %0s", test_name);
                else $display("FAIL  %0s with %0d failed checks", test_name, test_errors);
                errors += test_errors;
                tests_done++;
            end
        end
    end

endmodule

// File: tb_bus_arbiter.sv
`timescale 1ns/1ps

module tb_bus_arbiter
    import arb_pkg::*;
();

    localparam int         NUM_TESTS      = 9;
    localparam int         TIMEOUT_CYCLES = NUM_TESTS * 40;
    localparam logic [1:0] K_FETCH        = 2'd0;
    localparam logic [1:0] K_MEM          = 2'd1;
    localparam logic [1:0] K_BOTH         = 2'd2;
    localparam logic [1:0] K_WRITE        = 2'd3;

    logic  clk;
    logic  rst;
    logic  fetch_arvalid, fetch_arready, fetch_rready, fetch_rvalid, fetch_rlast;
    logic  mem_arvalid, mem_arready, mem_rready, mem_rvalid, mem_rlast;
    logic  mem_awvalid, mem_awready, mem_wvalid, mem_wlast, mem_wready, mem_bready, mem_bvalid;
    logic  io_arvalid, io_arready, io_rvalid, io_rlast, io_rready;
    logic  io_awvalid, io_awready, io_wvalid, io_wlast, io_wready, io_bvalid, io_bready;
    addr_t fetch_araddr, mem_araddr, mem_awaddr, io_araddr, io_awaddr;
    len_t  fetch_arlen, mem_arlen, mem_awlen, io_arlen, io_awlen;
    data_t fetch_rdata, mem_rdata, mem_wdata, io_rdata, io_wdata;
    strb_t mem_wstrb, io_wstrb;
    resp_t fetch_rresp, mem_rresp, mem_bresp, io_rresp, io_bresp;
    id_t   io_arid, io_rid, io_awid, io_bid;

    // Current table entry, also watched by the monitor
    logic         start, done;
    logic [127:0] test_name;
    logic         test_fetch, test_mem, test_write;
    addr_t        test_addr, test_mem_addr;
    len_t         test_len;
    resp_t        test_resp;
    int           tests_done, errors;

    logic [127:0] tbl_name [NUM_TESTS];
    logic [1:0]   tbl_kind [NUM_TESTS];
    addr_t        tbl_addr [NUM_TESTS];
    len_t         tbl_len  [NUM_TESTS];
    resp_t        tbl_resp [NUM_TESTS];

    // Slave model state
    logic [31:0] rng;
    logic        ar_hs, r_hs, aw_hs, w_hs, b_hs, wlast_q;
    addr_t       ar_addr_q, rd_addr;
    len_t        ar_len_q, rd_len, rd_beat;
    id_t         ar_id_q, aw_id_q, rd_id, wr_id;
    logic        rd_active, wr_active, b_pending;
    int          cycle_count;

    bus_arbiter u_dut (.*);

    tb_monitor u_monitor (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic set_entry(input int i, input logic [127:0] name, input logic [1:0] kind,
                             input addr_t addr, input len_t len, input resp_t resp);
        tbl_name[i] = name;
        tbl_kind[i] = kind;
        tbl_addr[i] = addr;
        tbl_len[i]  = len;
        tbl_resp[i] = resp;
    endtask

    task automatic request_read(input logic fetch, input addr_t addr);
        if (fetch) begin
            fetch_arvalid = 1'b1;
            fetch_araddr  = addr;
            fetch_arlen   = test_len;
        end else begin
            mem_arvalid = 1'b1;
            mem_araddr  = addr;
            mem_arlen   = test_len;
        end
    endtask

    task automatic finish_read(input logic fetch);
        if (fetch) begin
            do @(posedge clk); while (!(fetch_arvalid && fetch_arready));
            @(negedge clk);
            fetch_arvalid = 1'b0;
            do @(posedge clk); while (!(fetch_rvalid && fetch_rready && fetch_rlast));
        end else begin
            do @(posedge clk); while (!(mem_arvalid && mem_arready));
            @(negedge clk);
            mem_arvalid = 1'b0;
            do @(posedge clk); while (!(mem_rvalid && mem_rready && mem_rlast));
        end
    endtask

    task automatic run_write();
        mem_awvalid = 1'b1;
        mem_awaddr  = test_addr;
        mem_awlen   = test_len;
        do @(posedge clk); while (!(mem_awvalid && mem_awready));
        @(negedge clk);
        mem_awvalid = 1'b0;
        for (int b = 0; b <= test_len; b++) begin
            mem_wvalid = 1'b1;
            mem_wdata  = {test_addr, 24'd0, 8'(b)} ^ 64'h0123_4567_89ab_cdef;
            mem_wstrb  = 8'hff >> (b % 8);
            mem_wlast  = (b == test_len);
            do @(posedge clk); while (!(mem_wvalid && mem_wready));
            @(negedge clk);
        end
        mem_wvalid = 1'b0;
        mem_wlast  = 1'b0;
        do @(posedge clk); while (!(mem_bvalid && mem_bready));
    endtask

    // Handshakes are taken at the rising edge and acted on at the next falling edge
    always @(posedge clk) begin
        ar_hs     = io_arvalid && io_arready;
        r_hs      = io_rvalid && io_rready;
        aw_hs     = io_awvalid && io_awready;
        w_hs      = io_wvalid && io_wready;
        b_hs      = io_bvalid && io_bready;
        ar_addr_q = io_araddr;
        ar_len_q  = io_arlen;
        ar_id_q   = io_arid;
        aw_id_q   = io_awid;
        wlast_q   = io_wlast;
    end

    always @(negedge clk) begin
        if (rst) begin
            rd_active  = 1'b0;
            wr_active  = 1'b0;
            b_pending  = 1'b0;
            io_arready = 1'b0;
            io_rvalid  = 1'b0;
            io_awready = 1'b0;
            io_wready  = 1'b0;
            io_bvalid  = 1'b0;
        end else begin
            if (ar_hs) begin
                rd_active = 1'b1;
                rd_addr   = ar_addr_q;
                rd_len    = ar_len_q;
                rd_id     = ar_id_q;
                rd_beat   = '0;
            end
            if (r_hs) begin
                if (rd_beat == rd_len) rd_active = 1'b0;
                rd_beat = rd_beat + 1'b1;
            end
            if (aw_hs) begin
                wr_active = 1'b1;
                wr_id     = aw_id_q;
            end
            if (w_hs && wlast_q) b_pending = 1'b1;
            if (b_hs) begin
                wr_active = 1'b0;
                b_pending = 1'b0;
            end
            rng          = xorshift(rng);
            io_arready   = rng[0] | rng[1];
            io_awready   = rng[2] | rng[3];
            io_wready    = wr_active && !b_pending && (rng[4] | rng[5]);
            fetch_rready = rng[6] | rng[7];
            mem_rready   = rng[8] | rng[9];
            mem_bready   = rng[10] | rng[11];
            if (!(io_rvalid && !r_hs)) io_rvalid = rd_active && (rng[12] | rng[13]);
            io_rdata = {32'd0, rd_addr + {21'd0, rd_beat, 3'd0}} + {56'd0, rd_beat};
            io_rresp = test_resp;
            io_rlast = (rd_beat == rd_len);
            io_rid   = rd_id;
            if (!(io_bvalid && !b_hs)) io_bvalid = b_pending && (rng[14] | rng[15]);
            io_bresp = test_resp;
            io_bid   = wr_id;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped answering", cycle_count);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        rng = 32'd43335;
        cycle_count = 0;
        {fetch_arvalid, fetch_rready, mem_arvalid, mem_rready} = '0;
        {mem_awvalid, mem_wvalid, mem_wlast, mem_bready} = '0;
        {fetch_araddr, fetch_arlen, mem_araddr, mem_arlen, mem_awaddr, mem_awlen} = '0;
        {mem_wdata, mem_wstrb} = '0;
        {io_arready, io_rvalid, io_rlast, io_awready, io_wready, io_bvalid} = '0;
        {io_rdata, io_rresp, io_rid, io_bresp, io_bid} = '0;
        {start, done, test_fetch, test_mem, test_write} = '0;
        {test_name, test_addr, test_mem_addr, test_len, test_resp} = '0;
        set_entry(0, "fetch_single", K_FETCH, 32'h0000_1000, 8'd0, RESP_OKAY);
        set_entry(1, "fetch_burst", K_FETCH, 32'h0000_2000, 8'd3, RESP_OKAY);
        set_entry(2, "mem_burst", K_MEM, 32'h8000_0040, 8'd2, RESP_EXOKAY);
        set_entry(3, "both_reads", K_BOTH, 32'h0000_3000, 8'd1, RESP_OKAY);
        set_entry(4, "write_single", K_WRITE, 32'h8000_0100, 8'd0, RESP_OKAY);
        set_entry(5, "write_slverr", K_WRITE, 32'h8000_0200, 8'd3, RESP_SLVERR);
        set_entry(6, "fetch_slverr", K_FETCH, 32'h0000_4000, 8'd1, RESP_SLVERR);
        set_entry(7, "mem_after_err", K_MEM, 32'h8000_0300, 8'd0, RESP_OKAY);
        set_entry(8, "both_decerr", K_BOTH, 32'h0000_5000, 8'd2, RESP_DECERR);
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            @(negedge clk);
            test_name     = tbl_name[i];
            test_fetch    = (tbl_kind[i] == K_FETCH) || (tbl_kind[i] == K_BOTH);
            test_mem      = (tbl_kind[i] == K_MEM) || (tbl_kind[i] == K_BOTH);
            test_write    = (tbl_kind[i] == K_WRITE);
            test_addr     = tbl_addr[i];
            test_mem_addr = (tbl_kind[i] == K_BOTH) ? tbl_addr[i] + 32'h100 : tbl_addr[i];
            test_len      = tbl_len[i];
            test_resp     = tbl_resp[i];
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            if (test_fetch) request_read(1'b1, test_addr);
            if (test_mem) request_read(1'b0, test_mem_addr); // Raised together for both_*
            if (test_fetch) finish_read(1'b1);
            if (test_mem) finish_read(1'b0);
            if (test_write) run_write();
            @(negedge clk);
            done = 1'b1;
            @(negedge clk);
            done = 1'b0;
        end
        repeat (2) @(negedge clk);
        $display("Tests run: %0d of %0d, failed checks: %0d", tests_done, NUM_TESTS, errors);
        if (errors == 0 && tests_done == NUM_TESTS) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: compile.f
arb_pkg.sv
read_arbiter.sv
write_tracker.sv
bus_arbiter.sv
tb_monitor.sv
tb_bus_arbiter.sv
